// ==== src/segre_pkg.sv ====
package segre_pkg;

    // Data path and memory sizes
    localparam int WORD_SIZE             = 32;
    localparam int BYTES_PER_WORD        = WORD_SIZE / 8;
    localparam int CACHE_LINE_SIZE_BYTES = 16;
    localparam int WORDS_PER_LINE        = CACHE_LINE_SIZE_BYTES / BYTES_PER_WORD;
    localparam int MEM_BYTES             = 4096;
    localparam int MEM_ADDR_BITS         = $clog2(MEM_BYTES);

    // Cycles from a memory strobe to its ready pulse
    localparam int MEM_LATENCY  = 9;
    localparam int LAT_CNT_BITS = $clog2(MEM_LATENCY);

    // Direct-mapped cache geometry
    localparam int NUM_LINES   = 8;
    localparam int INDEX_BITS  = $clog2(NUM_LINES);
    localparam int OFFSET_BITS = $clog2(CACHE_LINE_SIZE_BYTES);
    localparam int TAG_BITS    = WORD_SIZE - INDEX_BITS - OFFSET_BITS;

    // Cache controller states
    localparam logic [1:0] CACHE_IDLE  = 2'd0;
    localparam logic [1:0] CACHE_FILL  = 2'd1;
    localparam logic [1:0] CACHE_WRITE = 2'd2;
    localparam logic [1:0] CACHE_RESP  = 2'd3;

    typedef enum logic [1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } memop_data_type_e;

    // Same line seen as bytes or as words
    typedef union packed {
        logic [CACHE_LINE_SIZE_BYTES-1:0][7:0]     bytes;
        logic [WORDS_PER_LINE-1:0][WORD_SIZE-1:0] words;
    } cache_line_u;

    // Low 1, 2 or 4 byte lanes of a store
    function automatic logic [BYTES_PER_WORD-1:0] byte_enable(memop_data_type_e dtype);
        case (dtype)
            BYTE:    return 4'b0001;
            HALF:    return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

endpackage

// ==== src/main_memory.sv ====
`timescale 1ns/1ps

module main_memory
    import segre_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // One-cycle request strobes
    input  logic                   mem_rd_i,
    input  logic                   mem_wr_i,

    // Held by the requester until ready
    input  memop_data_type_e       mem_type_i,
    input  logic [WORD_SIZE-1:0]   mem_addr_i,
    input  logic [WORD_SIZE-1:0]   mem_wdata_i,

    output logic                   mem_ready_o,
    output cache_line_u            mem_line_o
);

    logic [7:0]               mem_q [MEM_BYTES];
    logic [LAT_CNT_BITS-1:0]  count_q;
    logic                     pend_wr_q;
    logic [MEM_ADDR_BITS-1:0] local_addr;
    logic [BYTES_PER_WORD-1:0] wr_be;
    cache_line_u              line_d;

    // Only the low address bits reach the array
    assign local_addr = mem_addr_i[MEM_ADDR_BITS-1:0];
    assign wr_be      = byte_enable(mem_type_i);

    // Start-up contents: each byte holds its own low address bits
    initial begin
        for (int i = 0; i < MEM_BYTES; i++) begin
            mem_q[i] = i[7:0];
        end
    end

    // Latency countdown, restarted by every strobe
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q     <= '0;
            pend_wr_q   <= 1'b0;
            mem_ready_o <= 1'b0;
        end else begin
            mem_ready_o <= (count_q == LAT_CNT_BITS'(1));
            if (mem_rd_i || mem_wr_i) begin
                count_q   <= LAT_CNT_BITS'(MEM_LATENCY - 1);
                pend_wr_q <= mem_wr_i;
            end else if (count_q != '0) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    // Gather the line around the aligned address
    always_comb begin
        line_d = '0;
        for (int i = 0; i < CACHE_LINE_SIZE_BYTES; i++) begin
            line_d.bytes[i] = mem_q[{local_addr[MEM_ADDR_BITS-1:OFFSET_BITS], OFFSET_BITS'(i)}];
        end
    end

    // Line register loads on the edge that raises ready
    always_ff @(posedge clk_i) begin
        if (count_q == LAT_CNT_BITS'(1) && !pend_wr_q) begin
            mem_line_o <= line_d;
        end
    end

    // Store lands at the end of the ready cycle
    always @(posedge clk_i) begin
        if (mem_ready_o && pend_wr_q) begin
            for (int b = 0; b < BYTES_PER_WORD; b++) begin
                if (wr_be[b]) begin
                    mem_q[local_addr + MEM_ADDR_BITS'(b)] <= mem_wdata_i[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== src/data_cache.sv ====
`timescale 1ns/1ps

module data_cache
    import segre_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,

    // Core side
    input  logic                   req_i,
    input  logic                   we_i,
    input  memop_data_type_e       data_type_i,
    input  logic [WORD_SIZE-1:0]   addr_i,
    input  logic [WORD_SIZE-1:0]   wdata_i,
    output logic [WORD_SIZE-1:0]   rdata_o,
    output logic                   done_o,
    output logic                   busy_o,

    // Memory side
    output logic                   mem_rd_o,
    output logic                   mem_wr_o,
    output memop_data_type_e       mem_type_o,
    output logic [WORD_SIZE-1:0]   mem_addr_o,
    output logic [WORD_SIZE-1:0]   mem_wdata_o,
    input  logic                   mem_ready_i,
    input  cache_line_u            mem_line_i
);

    logic [TAG_BITS-1:0]       tag_mem [NUM_LINES];
    cache_line_u               line_mem [NUM_LINES];
    logic [NUM_LINES-1:0]      valid_q;
    logic [1:0]                state_q;
    logic                      hit_q;

    // Request captured at acceptance
    logic [WORD_SIZE-1:0]      addr_q;
    logic [WORD_SIZE-1:0]      wdata_q;
    memop_data_type_e          type_q;
    logic [WORD_SIZE-1:0]      rdata_q;

    logic [TAG_BITS-1:0]       in_tag;
    logic [INDEX_BITS-1:0]     in_idx;
    logic [OFFSET_BITS-1:0]    in_off;
    logic [TAG_BITS-1:0]       req_tag;
    logic [INDEX_BITS-1:0]     req_idx;
    logic [OFFSET_BITS-1:0]    req_off;
    logic                      lookup_hit;
    logic                      accept;
    logic [BYTES_PER_WORD-1:0] st_be;
    cache_line_u               fill_line;
    cache_line_u               merged_line;

    assign {in_tag, in_idx, in_off}    = addr_i;
    assign {req_tag, req_idx, req_off} = addr_q;

    assign lookup_hit = valid_q[in_idx] && (tag_mem[in_idx] == in_tag);
    assign accept     = req_i && (state_q == CACHE_IDLE);
    assign st_be      = byte_enable(type_q);

    assign busy_o      = (state_q != CACHE_IDLE);
    assign done_o      = (state_q == CACHE_RESP);
    assign rdata_o     = rdata_q;
    assign mem_addr_o  = addr_q;
    assign mem_type_o  = type_q;
    assign mem_wdata_o = wdata_q;

    // Pick the word, then the lane, zero-extended
    function automatic logic [WORD_SIZE-1:0] select_load(cache_line_u line,
                                                         logic [OFFSET_BITS-1:0] off,
                                                         memop_data_type_e dtype);
        logic [WORD_SIZE-1:0] word;
        word = line.words[off[OFFSET_BITS-1:2]];
        case (dtype)
            BYTE:    return {{(WORD_SIZE-8){1'b0}}, word[{off[1:0], 3'b000} +: 8]};
            HALF:    return {{(WORD_SIZE-16){1'b0}}, word[{off[1], 4'b0000} +: 16]};
            default: return word;
        endcase
    endfunction

    // Refill copies the returned line word by word
    always_comb begin
        fill_line = '0;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            fill_line.words[w] = mem_line_i.words[w];
        end
    end

    // Store hit patches only the written bytes
    always_comb begin
        merged_line = line_mem[req_idx];
        for (int b = 0; b < BYTES_PER_WORD; b++) begin
            if (st_be[b]) begin
                merged_line.bytes[req_off + OFFSET_BITS'(b)] = wdata_q[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q  <= CACHE_IDLE;
            valid_q  <= '0;
            hit_q    <= 1'b0;
            mem_rd_o <= 1'b0;
            mem_wr_o <= 1'b0;
        end else begin
            mem_rd_o <= 1'b0;
            mem_wr_o <= 1'b0;
            case (state_q)
                CACHE_IDLE: begin
                    if (req_i) begin
                        hit_q <= lookup_hit;
                        if (we_i) begin
                            // Every store goes through to memory
                            mem_wr_o <= 1'b1;
                            state_q  <= CACHE_WRITE;
                        end else if (lookup_hit) begin
                            state_q <= CACHE_RESP;
                        end else begin
                            mem_rd_o <= 1'b1;
                            state_q  <= CACHE_FILL;
                        end
                    end
                end
                CACHE_FILL: begin
                    if (mem_ready_i) begin
                        valid_q[req_idx] <= 1'b1;
                        state_q          <= CACHE_RESP;
                    end
                end
                CACHE_WRITE: begin
                    if (mem_ready_i) begin
                        state_q <= CACHE_RESP;
                    end
                end
                default: begin
                    state_q <= CACHE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
            type_q  <= data_type_i;
        end

        // Hits answer from the array, misses from the returning line
        if (accept && !we_i && lookup_hit) begin
            rdata_q <= select_load(line_mem[in_idx], in_off, data_type_i);
        end else if (state_q == CACHE_FILL && mem_ready_i) begin
            rdata_q <= select_load(mem_line_i, req_off, type_q);
        end

        if (state_q == CACHE_FILL && mem_ready_i) begin
            line_mem[req_idx] <= fill_line;
            tag_mem[req_idx]  <= req_tag;
        end else if (state_q == CACHE_WRITE && mem_ready_i && hit_q) begin
            line_mem[req_idx] <= merged_line;
        end
    end

endmodule

// ==== src/segre_mem_top.sv ====
`timescale 1ns/1ps

module segre_mem_top
    import segre_pkg::*;
(
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  logic                   req_i,
    input  logic                   we_i,
    input  memop_data_type_e       data_type_i,
    input  logic [WORD_SIZE-1:0]   addr_i,
    input  logic [WORD_SIZE-1:0]   wdata_i,
    output logic [WORD_SIZE-1:0]   rdata_o,
    output logic                   done_o,
    output logic                   busy_o
);

    // Cache to memory link
    logic                 mem_rd;
    logic                 mem_wr;
    memop_data_type_e     mem_type;
    logic [WORD_SIZE-1:0] mem_addr;
    logic [WORD_SIZE-1:0] mem_wdata;
    logic                 mem_ready;
    cache_line_u          mem_line;

    data_cache u_data_cache (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .data_type_i (data_type_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rdata_o     (rdata_o),
        .done_o      (done_o),
        .busy_o      (busy_o),
        .mem_rd_o    (mem_rd),
        .mem_wr_o    (mem_wr),
        .mem_type_o  (mem_type),
        .mem_addr_o  (mem_addr),
        .mem_wdata_o (mem_wdata),
        .mem_ready_i (mem_ready),
        .mem_line_i  (mem_line)
    );

    main_memory u_main_memory (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .mem_rd_i    (mem_rd),
        .mem_wr_i    (mem_wr),
        .mem_type_i  (mem_type),
        .mem_addr_i  (mem_addr),
        .mem_wdata_i (mem_wdata),
        .mem_ready_o (mem_ready),
        .mem_line_o  (mem_line)
    );

endmodule

// ==== tests/segre_mem_props.sv ====
`timescale 1ns/1ps

module segre_mem_props
    import segre_pkg::*;
(
    input logic clk_i,
    input logic rst_n_i,
    input logic rd_i,
    input logic wr_i,
    input logic ready_i,
    input logic done_i,
    input logic busy_i
);

    logic                   strobe;
    logic [MEM_LATENCY-1:0] strobe_hist_q;

    assign strobe = rd_i || wr_i;

    // Bit n is set when a strobe was seen n+1 cycles ago
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            strobe_hist_q <= '0;
        end else begin
            strobe_hist_q <= {strobe_hist_q[MEM_LATENCY-2:0], strobe};
        end
    end

    done_single: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !done_i)
        else $error("done_o stayed high for more than one cycle");

    ready_single: assert property (@(posedge clk_i) disable iff (!rst_n_i) ready_i |=> !ready_i)
        else $error("mem_ready_o stayed high for more than one cycle");

    // Ready exactly MEM_LATENCY cycles after a strobe, and never without one
    ready_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ready_i == strobe_hist_q[MEM_LATENCY-1])
        else $error("mem_ready_o does not follow a strobe by the memory latency");

    no_strobe_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        strobe |-> (strobe_hist_q[MEM_LATENCY-2:0] == '0))
        else $error("memory strobe issued while memory was busy");

    idle_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i) done_i |=> !busy_i)
        else $error("busy_o still high in the cycle after done_o");

endmodule

bind data_cache segre_mem_props u_cache_props (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rd_i    (mem_rd_o),
    .wr_i    (mem_wr_o),
    .ready_i (mem_ready_i),
    .done_i  (done_o),
    .busy_i  (busy_o)
);

// Memory side has no core port, so done and busy are tied off
bind main_memory segre_mem_props u_memory_props (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .rd_i    (mem_rd_i),
    .wr_i    (mem_wr_i),
    .ready_i (mem_ready_o),
    .done_i  (1'b0),
    .busy_i  (1'b0)
);

// ==== tests/segre_mem_tb.sv ====
`timescale 1ns/1ps

module segre_mem_tb
    import segre_pkg::*;
();

    localparam int WAIT_LIMIT   = 100;
    localparam int RANDOM_OPS   = 300;
    localparam int MISS_LATENCY = MEM_LATENCY + 2;

    logic                 clk_i;
    logic                 rst_n_i;
    logic                 req_i;
    logic                 we_i;
    memop_data_type_e     data_type_i;
    logic [WORD_SIZE-1:0] addr_i;
    logic [WORD_SIZE-1:0] wdata_i;
    logic [WORD_SIZE-1:0] rdata_o;
    logic                 done_o;
    logic                 busy_o;

    // Reference memory and a shadow of the cache tags
    logic [7:0]           ref_mem [MEM_BYTES];
    logic [TAG_BITS-1:0]  ref_tag [NUM_LINES];
    logic                 ref_valid [NUM_LINES];
    integer               seed;
    int                   data_errors;
    int                   latency_errors;
    int                   flag_errors;
    int                   other_errors;
    int                   num_accesses;
    logic                 timed_out;

    segre_mem_top uut (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .we_i        (we_i),
        .data_type_i (data_type_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .rdata_o     (rdata_o),
        .done_o      (done_o),
        .busy_o      (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever begin
            #10 clk_i = ~clk_i;
        end
    end

    function automatic int access_bytes(memop_data_type_e dtype);
        case (dtype)
            BYTE:    return 1;
            HALF:    return 2;
            default: return 4;
        endcase
    endfunction

    // Little-endian read from the reference, zero-extended
    function automatic logic [WORD_SIZE-1:0] model_load(logic [WORD_SIZE-1:0] addr,
                                                        memop_data_type_e dtype);
        logic [WORD_SIZE-1:0] value;
        int                   a;
        value = '0;
        for (int b = 0; b < access_bytes(dtype); b++) begin
            a = int'(addr % MEM_BYTES) + b;
            value[8*b +: 8] = ref_mem[a];
        end
        return value;
    endfunction

    function automatic void model_store(logic [WORD_SIZE-1:0] addr, memop_data_type_e dtype,
                                        logic [WORD_SIZE-1:0] wdata);
        int a;
        for (int b = 0; b < access_bytes(dtype); b++) begin
            a = int'(addr % MEM_BYTES) + b;
            ref_mem[a] = wdata[8*b +: 8];
        end
    endfunction

    // Direct-mapped lookup; only a load miss allocates
    function automatic int model_latency(logic we, logic [WORD_SIZE-1:0] addr);
        int                  idx;
        logic [TAG_BITS-1:0] tag;
        idx = int'(addr[OFFSET_BITS +: INDEX_BITS]);
        tag = addr[WORD_SIZE-1 -: TAG_BITS];
        if (we) begin
            return MISS_LATENCY;
        end
        if (ref_valid[idx] && ref_tag[idx] == tag) begin
            return 1;
        end
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tag;
        return MISS_LATENCY;
    endfunction

    task automatic check_data(input string name, input logic [WORD_SIZE-1:0] addr,
                              input logic [WORD_SIZE-1:0] actual,
                              input logic [WORD_SIZE-1:0] expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s got %h expected %h (addr %h)",
                     $time, name, actual, expected, addr);
            data_errors++;
        end
    endtask

    task automatic check_latency(input string name, input logic [WORD_SIZE-1:0] addr,
                                 input int actual, input int expected);
        if (actual != expected) begin
            $display("ERROR at %0t: %s latency got %0d expected %0d (addr %h)",
                     $time, name, actual, expected, addr);
            latency_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s got %b expected %b", $time, name, actual, expected);
            flag_errors++;
        end
    endtask

    task automatic report_and_finish();
        $display("Accesses %0d, errors: data %0d, latency %0d, flag %0d, other %0d",
                 num_accesses, data_errors, latency_errors, flag_errors, other_errors);
        if (data_errors + latency_errors + flag_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    // After a timeout no further request is issued
    task automatic note_timeout(input string what);
        $display("Timeout after %0d cycles: %s", WAIT_LIMIT, what);
        other_errors++;
        timed_out = 1'b1;
    endtask

    // One request: wait for idle, strobe, count cycles to done, compare
    task automatic run_access(input logic we, input memop_data_type_e dtype,
                              input logic [WORD_SIZE-1:0] addr,
                              input logic [WORD_SIZE-1:0] wdata);
        int                   cycles;
        int                   exp_latency;
        logic [WORD_SIZE-1:0] exp_data;
        if (timed_out) begin
            return;
        end
        exp_latency = model_latency(we, addr);
        exp_data    = model_load(addr, dtype);
        @(negedge clk_i);
        cycles = 0;
        while (busy_o && cycles < WAIT_LIMIT) begin
            @(negedge clk_i);
            cycles++;
        end
        if (busy_o) begin
            note_timeout("the cache never went idle before a request");
        end else begin
            req_i       = 1'b1;
            we_i        = we;
            data_type_i = dtype;
            addr_i      = addr;
            wdata_i     = wdata;
            @(negedge clk_i);
            req_i  = 1'b0;
            cycles = 1;
            while (!done_o && cycles < WAIT_LIMIT) begin
                check_flag("busy_o", busy_o, 1'b1);
                @(negedge clk_i);
                cycles++;
            end
            if (!done_o) begin
                note_timeout("done_o never came for a request");
            end else begin
                check_latency("done_o", addr, cycles, exp_latency);
                check_flag("busy_o", busy_o, 1'b1);
                if (we) begin
                    model_store(addr, dtype, wdata);
                end else begin
                    check_data("rdata_o", addr, rdata_o, exp_data);
                end
                num_accesses++;
            end
        end
    endtask

    task automatic random_access();
        logic [WORD_SIZE-1:0] r;
        logic [WORD_SIZE-1:0] wdata;
        logic [WORD_SIZE-1:0] addr;
        memop_data_type_e     dtype;
        r     = $random(seed);
        wdata = $random(seed);
        dtype = (r[1:0] == 2'd3) ? WORD : memop_data_type_e'(r[1:0]);
        addr  = WORD_SIZE'(r[16:8]);
        // Natural alignment for the access size
        if (dtype == HALF) addr[0] = 1'b0;
        if (dtype == WORD) addr[1:0] = 2'b00;
        run_access(r[4:2] < 3'd3, dtype, addr, wdata);
    endtask

    initial begin
        seed           = 32'h1fdb;
        data_errors    = 0;
        latency_errors = 0;
        flag_errors    = 0;
        other_errors   = 0;
        num_accesses   = 0;
        timed_out      = 1'b0;
        rst_n_i        = 1'b0;
        req_i          = 1'b0;
        we_i           = 1'b0;
        data_type_i    = WORD;
        addr_i         = '0;
        wdata_i        = '0;
        for (int i = 0; i < MEM_BYTES; i++) begin
            ref_mem[i] = i[7:0];
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        check_flag("done_o", done_o, 1'b0);
        check_flag("busy_o", busy_o, 1'b0);

        // Start-up pattern in all three sizes, second pair hits the same line
        run_access(1'b0, BYTE, 32'h025, '0);
        run_access(1'b0, HALF, 32'h046, '0);
        run_access(1'b0, WORD, 32'h1f8, '0);
        run_access(1'b0, BYTE, 32'h1ff, '0);
        run_access(1'b0, HALF, 32'h1fa, '0);

        // Overlapping stores, then loads of the merged bytes
        run_access(1'b1, WORD, 32'h080, 32'hc3a5_5a3c);
        run_access(1'b1, HALF, 32'h082, 32'h0000_7e81);
        run_access(1'b1, BYTE, 32'h081, 32'h0000_0042);
        run_access(1'b0, WORD, 32'h080, '0);
        run_access(1'b1, BYTE, 32'h083, 32'h0000_00f0);
        run_access(1'b0, WORD, 32'h080, '0);
        run_access(1'b0, HALF, 32'h082, '0);

        // Index 3 shared by two tags, store lands on the evicted line
        run_access(1'b0, WORD, 32'h030, '0);
        run_access(1'b0, WORD, 32'h0b0, '0);
        run_access(1'b0, WORD, 32'h030, '0);
        run_access(1'b1, WORD, 32'h0b4, 32'h1234_5678);
        run_access(1'b0, WORD, 32'h0b4, '0);
        run_access(1'b0, BYTE, 32'h036, '0);

        repeat (RANDOM_OPS) random_access();
        report_and_finish();
    end

endmodule

// ==== src.f ====
src/segre_pkg.sv
src/main_memory.sv
src/data_cache.sv
src/segre_mem_top.sv
tests/segre_mem_props.sv
tests/segre_mem_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build segre_mem_tb with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module segre_mem_tb \
		-Mdir obj_dir -o segre_mem_tb
	./obj_dir/segre_mem_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Test OK$$" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
